// File: rtl/wb_pkg.sv
`default_nettype none

package wb_pkg;

	// ------------------------------
	// widths of the generated buffer
	// ------------------------------
	localparam int LANES       = 16;              // weights packed per word
	localparam int ROWS        = 3;               // kernel-row banks
	localparam int ADDR_BITS   = 6;               // 64 words per bank
	localparam int WEIGHT_BITS = 18;
	localparam int WORD_BITS   = LANES * WEIGHT_BITS;
	localparam int DEPTH       = 1 << ADDR_BITS;

	// a full product is 36 bits, sixteen of them need 4 more for growth
	localparam int PROD_BITS   = 2 * WEIGHT_BITS;
	localparam int ACC_BITS    = PROD_BITS + 4;

	// ------------------------------
	// vector types
	// ------------------------------
	typedef logic signed [WEIGHT_BITS-1:0] weight_t;
	typedef logic        [WORD_BITS-1:0]   word_t;    // lane k sits at bits 18k +: 18
	typedef logic        [ADDR_BITS-1:0]   addr_t;
	typedef logic        [1:0]             bank_t;    // only 0 to 2 select a bank
	typedef logic signed [ACC_BITS-1:0]    acc_t;
	typedef logic        [3:0]             lane_cnt_t;

	// loader FSM
	typedef enum logic {
		LOAD_COLLECT,
		LOAD_COMMIT
	} load_state_t;

endpackage

`default_nettype wire

// File: rtl/weight_read_if.sv
`timescale 1ns/1ps
`default_nettype none

// read path between the weight buffer and the dot-product stage
interface weight_read_if;

	logic          rd_strobe;
	wb_pkg::addr_t rd_index;
	wb_pkg::word_t act;                    // activation word, aligned with rows
	wb_pkg::word_t rows [wb_pkg::ROWS];    // rows at index, index+1, index+2
	logic          rows_valid;

	modport buffer (
		input  rd_strobe, rd_index,
		output rows, rows_valid
	);

	modport dot (
		output rd_strobe, rd_index, act,
		input  rows, rows_valid
	);

endinterface

`default_nettype wire

// File: rtl/weight_bank.sv
`timescale 1ns/1ps
`default_nettype none

// one kernel-row bank, a single port that either writes or reads each cycle
module weight_bank (
	input  wire logic          clk,
	input  wire logic          we,
	input  wire wb_pkg::addr_t addr,
	input  wire wb_pkg::word_t data,
	output wb_pkg::word_t      q
);

	wb_pkg::word_t mem [wb_pkg::DEPTH];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= data;
		end else begin
			q <= mem[addr];    // q holds its last value during a write
		end
	end

endmodule

`default_nettype wire

// File: rtl/weight_loader.sv
`timescale 1ns/1ps
`default_nettype none

// collects 16 serial weights into one word, then writes it into one bank
module weight_loader (
	input  wire logic          clk,
	input  wire logic          reset,
	input  wire logic          lane_valid,
	input  wire wb_pkg::weight_t lane_data,
	input  wire wb_pkg::bank_t load_bank,
	input  wire wb_pkg::addr_t load_addr,
	output logic               wr_en,
	output wb_pkg::bank_t      wr_bank,
	output wb_pkg::addr_t      wr_addr,
	output wb_pkg::word_t      wr_word,
	output logic               load_busy
);

	wb_pkg::load_state_t state;
	wb_pkg::lane_cnt_t   lane_cnt;
	logic                lane_accept;
	logic                last_lane;

	// lanes that arrive during the commit cycle are dropped
	assign lane_accept = (state == wb_pkg::LOAD_COLLECT) && lane_valid;
	assign last_lane   = (lane_cnt == wb_pkg::lane_cnt_t'(wb_pkg::LANES - 1));

	assign wr_en     = (state == wb_pkg::LOAD_COMMIT);
	assign load_busy = lane_accept || (lane_cnt != '0) || wr_en;

	// ------------------------------
	// control
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= wb_pkg::LOAD_COLLECT;
			lane_cnt <= '0;
		end else begin
			case (state)
				wb_pkg::LOAD_COLLECT: begin
					if (lane_valid) begin
						lane_cnt <= lane_cnt + wb_pkg::lane_cnt_t'(1);    // wraps to 0 after lane 15
						if (last_lane) begin
							state <= wb_pkg::LOAD_COMMIT;
						end
					end
				end
				wb_pkg::LOAD_COMMIT: state <= wb_pkg::LOAD_COLLECT;
				default:             state <= wb_pkg::LOAD_COLLECT;
			endcase
		end
	end

	// ------------------------------
	// payload
	// ------------------------------
	always_ff @(posedge clk) begin
		if (lane_accept) begin
			// shift in from the top so lane 0 ends up in bits 17:0
			wr_word <= {lane_data, wr_word[wb_pkg::WORD_BITS-1:wb_pkg::WEIGHT_BITS]};
			if (lane_cnt == '0) begin
				wr_bank <= load_bank;
				wr_addr <= load_addr;
			end
		end
	end

	a_bank_in_range: assert property (@(posedge clk) disable iff (reset)
		(lane_accept && lane_cnt == '0) |-> (load_bank < wb_pkg::bank_t'(wb_pkg::ROWS)))
		else $error("load_bank %0d selects no bank", load_bank);

endmodule

`default_nettype wire

// File: rtl/weight_buffer.sv
`timescale 1ns/1ps
`default_nettype none

// three kernel-row banks; one index returns the rows at index, index+1 and index+2
module weight_buffer (
	input  wire logic          clk,
	input  wire logic          reset,
	weight_read_if.buffer      rd,
	input  wire logic          wr_en,
	input  wire wb_pkg::bank_t wr_bank,
	input  wire wb_pkg::addr_t wr_addr,
	input  wire wb_pkg::word_t wr_word
);

	wb_pkg::addr_t rd_addr_q [wb_pkg::ROWS];
	wb_pkg::word_t bank_q    [wb_pkg::ROWS];
	logic          strobe_q;

	// ------------------------------
	// read address and valid pipe
	// ------------------------------
	always_ff @(posedge clk) begin
		for (int r = 0; r < wb_pkg::ROWS; r++) begin
			rd_addr_q[r] <= rd.rd_index + wb_pkg::addr_t'(r);    // wraps modulo 64
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			strobe_q      <= 1'b0;
			rd.rows_valid <= 1'b0;
		end else begin
			strobe_q      <= rd.rd_strobe;
			rd.rows_valid <= strobe_q;    // bank data lands in the same cycle
		end
	end

	// ------------------------------
	// banks
	// ------------------------------
	for (genvar r = 0; r < wb_pkg::ROWS; r++) begin : g_bank
		logic          bank_we;
		wb_pkg::addr_t bank_addr;

		// a write takes over the port of the selected bank only
		assign bank_we   = wr_en && (wr_bank == wb_pkg::bank_t'(r));
		assign bank_addr = bank_we ? wr_addr : rd_addr_q[r];

		weight_bank weight_bank_inst (
			.clk  (clk),
			.we   (bank_we),
			.addr (bank_addr),
			.data (wr_word),
			.q    (bank_q[r])
		);

		assign rd.rows[r] = bank_q[r];
	end

	// the loader and the read port come from different sources at the top
	a_no_read_during_write: assert property (@(posedge clk) disable iff (reset)
		!(rd.rd_strobe && wr_en))
		else $error("read strobe collides with a bank write");

endmodule

`default_nettype wire

// File: rtl/kernel_row_dot.sv
`timescale 1ns/1ps
`default_nettype none

// multiplies one activation word by each kernel row and sums the lanes
module kernel_row_dot (
	input  wire logic          clk,
	input  wire logic          reset,
	weight_read_if.dot         rd,
	input  wire logic          top_strobe,
	input  wire wb_pkg::addr_t top_index,
	input  wire wb_pkg::word_t act_word,
	output logic               sum_valid,
	output wb_pkg::acc_t       sums [wb_pkg::ROWS]
);

	wb_pkg::word_t                     act_q;
	logic signed [wb_pkg::PROD_BITS-1:0] prod_q [wb_pkg::ROWS][wb_pkg::LANES];
	logic                              prod_valid;
	wb_pkg::acc_t                      row_total [wb_pkg::ROWS];

	function automatic wb_pkg::weight_t lane_of(input wb_pkg::word_t w, input int k);
		return wb_pkg::weight_t'(w[k*wb_pkg::WEIGHT_BITS +: wb_pkg::WEIGHT_BITS]);
	endfunction

	// request goes straight to the buffer
	assign rd.rd_strobe = top_strobe;
	assign rd.rd_index  = top_index;

	// ------------------------------
	// activation delay, two stages
	// ------------------------------
	always_ff @(posedge clk) begin
		act_q  <= act_word;
		rd.act <= act_q;    // meets the rows at rows_valid
	end

	// ------------------------------
	// product stage
	// ------------------------------
	always_ff @(posedge clk) begin
		for (int r = 0; r < wb_pkg::ROWS; r++) begin
			for (int k = 0; k < wb_pkg::LANES; k++) begin
				prod_q[r][k] <= (wb_pkg::PROD_BITS)'(lane_of(rd.act, k)) *
					(wb_pkg::PROD_BITS)'(lane_of(rd.rows[r], k));
			end
		end
	end

	// ------------------------------
	// adder tree and sum stage
	// ------------------------------
	always_comb begin
		for (int r = 0; r < wb_pkg::ROWS; r++) begin
			row_total[r] = '0;
			for (int k = 0; k < wb_pkg::LANES; k++) begin
				row_total[r] = row_total[r] + wb_pkg::acc_t'(prod_q[r][k]);    // sign extended
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int r = 0; r < wb_pkg::ROWS; r++) begin
			sums[r] <= row_total[r];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			prod_valid <= 1'b0;
			sum_valid  <= 1'b0;
		end else begin
			prod_valid <= rd.rows_valid;
			sum_valid  <= prod_valid;
		end
	end

	// a sum leaves four cycles after its read strobe went to the buffer
	a_sum_follows_strobe: assert property (@(posedge clk) disable iff (reset)
		sum_valid |-> $past(rd.rd_strobe, 4))
		else $error("sum_valid without a read strobe four cycles earlier");

endmodule

`default_nettype wire

// File: rtl/conv_weight_engine.sv
`timescale 1ns/1ps
`default_nettype none

// weight side of the convolution engine: loader, banked buffer, row dot products
module conv_weight_engine (
	input  wire logic            clk,
	input  wire logic            reset,
	input  wire logic            lane_valid,
	input  wire wb_pkg::weight_t lane_data,
	input  wire wb_pkg::bank_t   load_bank,
	input  wire wb_pkg::addr_t   load_addr,
	input  wire logic            rd_strobe,
	input  wire wb_pkg::addr_t   rd_index,
	input  wire wb_pkg::word_t   act_word,
	output logic                 sum_valid,
	output wb_pkg::acc_t         sum_0,
	output wb_pkg::acc_t         sum_1,
	output wb_pkg::acc_t         sum_2,
	output logic                 load_busy
);

	weight_read_if rd_if ();

	logic          wr_en;
	wb_pkg::bank_t wr_bank;
	wb_pkg::addr_t wr_addr;
	wb_pkg::word_t wr_word;
	wb_pkg::acc_t  sums [wb_pkg::ROWS];

	weight_loader weight_loader_inst (
		.clk        (clk),
		.reset      (reset),
		.lane_valid (lane_valid),
		.lane_data  (lane_data),
		.load_bank  (load_bank),
		.load_addr  (load_addr),
		.wr_en      (wr_en),
		.wr_bank    (wr_bank),
		.wr_addr    (wr_addr),
		.wr_word    (wr_word),
		.load_busy  (load_busy)
	);

	weight_buffer weight_buffer_inst (
		.clk     (clk),
		.reset   (reset),
		.rd      (rd_if.buffer),
		.wr_en   (wr_en),
		.wr_bank (wr_bank),
		.wr_addr (wr_addr),
		.wr_word (wr_word)
	);

	kernel_row_dot kernel_row_dot_inst (
		.clk        (clk),
		.reset      (reset),
		.rd         (rd_if.dot),
		.top_strobe (rd_strobe),
		.top_index  (rd_index),
		.act_word   (act_word),
		.sum_valid  (sum_valid),
		.sums       (sums)
	);

	assign sum_0 = sums[0];
	assign sum_1 = sums[1];
	assign sum_2 = sums[2];

endmodule

`default_nettype wire

// File: sim/conv_weight_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_weight_engine_tb;

	localparam int N_READS = 12;
	localparam int TIMEOUT = 40;    // cycles allowed for any single wait

	logic            clk;
	logic            reset;
	logic            lane_valid;
	wb_pkg::weight_t lane_data;
	wb_pkg::bank_t   load_bank;
	wb_pkg::addr_t   load_addr;
	logic            rd_strobe;
	wb_pkg::addr_t   rd_index;
	wb_pkg::word_t   act_word;
	logic            sum_valid;
	wb_pkg::acc_t    sum_0;
	wb_pkg::acc_t    sum_1;
	wb_pkg::acc_t    sum_2;
	logic            load_busy;

	integer        seed = 409;
	int            step;
	wb_pkg::word_t shadow [wb_pkg::ROWS][wb_pkg::DEPTH];    // what the banks should hold
	int            exp_step [$];    // negedge step at which each read must show up
	wb_pkg::acc_t  exp_sum  [$];    // three per read with row 0 first

	// a reload rewrites bank 1 at index+1 before the read
	int tbl_index  [N_READS] = '{0, 1, 17, 62, 63, 30, 40, 39, 41, 40, 62, 63};
	int tbl_seed   [N_READS] = '{101, 102, 103, 104, 105, 106, 107, 108, 109, 101, 104, 110};
	int tbl_reload [N_READS] = '{0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0};

	conv_weight_engine conv_weight_engine_inst (
		.clk        (clk),
		.reset      (reset),
		.lane_valid (lane_valid),
		.lane_data  (lane_data),
		.load_bank  (load_bank),
		.load_addr  (load_addr),
		.rd_strobe  (rd_strobe),
		.rd_index   (rd_index),
		.act_word   (act_word),
		.sum_valid  (sum_valid),
		.sum_0      (sum_0),
		.sum_1      (sum_1),
		.sum_2      (sum_2),
		.load_busy  (load_busy)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------
	// checks and reference model
	// ------------------------------
	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_acc(input string name, input wb_pkg::acc_t got,
			input wb_pkg::acc_t expected);
		if (got !== expected)
			stop_with_failure($sformatf("Error at %0t ns: %s expected %0d, got %0d",
				$time, name, expected, got));
	endtask

	task automatic check_bit(input string name, input logic got, input logic expected);
		if (got !== expected)
			stop_with_failure($sformatf("Error at %0t ns: %s expected %b, got %b",
				$time, name, expected, got));
	endtask

	function automatic wb_pkg::weight_t lane_value(input wb_pkg::word_t w, input int k);
		return w[k*wb_pkg::WEIGHT_BITS +: wb_pkg::WEIGHT_BITS];
	endfunction

	function automatic wb_pkg::word_t random_word();
		wb_pkg::word_t w;
		for (int k = 0; k < wb_pkg::LANES; k++)
			w[k*wb_pkg::WEIGHT_BITS +: wb_pkg::WEIGHT_BITS] = wb_pkg::weight_t'($random(seed));
		return w;
	endfunction

	function automatic wb_pkg::word_t act_from_seed(input int act_seed);
		integer        s;
		wb_pkg::word_t w;
		s = act_seed;
		for (int k = 0; k < wb_pkg::LANES; k++)
			w[k*wb_pkg::WEIGHT_BITS +: wb_pkg::WEIGHT_BITS] = wb_pkg::weight_t'($random(s));
		return w;
	endfunction

	// row r is the signed dot product with bank r at index+r, wrapping at 64
	function automatic wb_pkg::acc_t expected_row(input int r, input int index,
			input wb_pkg::word_t act);
		longint        total;
		wb_pkg::addr_t a;
		a = wb_pkg::addr_t'((index + r) % wb_pkg::DEPTH);
		total = 0;
		for (int k = 0; k < wb_pkg::LANES; k++)
			total += longint'(lane_value(act, k)) * longint'(lane_value(shadow[r][a], k));
		return wb_pkg::acc_t'(total);
	endfunction

	// ------------------------------
	// cycle stepping
	// ------------------------------
	// outputs are checked on the falling edge, before new inputs go out
	task automatic next_cycle();
		@(negedge clk);
		step++;
		if (exp_step.size() > 0 && exp_step[0] == step) begin
			void'(exp_step.pop_front());
			check_bit("sum_valid", sum_valid, 1'b1);
			check_acc("sum_0", sum_0, exp_sum.pop_front());
			check_acc("sum_1", sum_1, exp_sum.pop_front());
			check_acc("sum_2", sum_2, exp_sum.pop_front());
		end else begin
			check_bit("sum_valid", sum_valid, 1'b0);
		end
	endtask

	task automatic load_word(input int bank, input int addr, input wb_pkg::word_t w);
		int waited;
		for (int k = 0; k < wb_pkg::LANES; k++) begin
			next_cycle();
			if (k > 0)
				check_bit("load_busy", load_busy, 1'b1);
			lane_valid = 1'b1;
			lane_data  = lane_value(w, k);
			load_bank  = wb_pkg::bank_t'(bank);
			load_addr  = wb_pkg::addr_t'(addr);
		end
		next_cycle();
		check_bit("load_busy", load_busy, 1'b1);    // write cycle
		lane_valid = 1'b0;
		waited = 0;
		do begin
			next_cycle();
			waited++;
			if (waited > TIMEOUT)
				stop_with_failure("load_busy stayed high after a word write");
		end while (load_busy !== 1'b0);
		shadow[bank][addr] = w;
	endtask

	task automatic issue_read(input int index, input int act_seed);
		wb_pkg::word_t act;
		act = act_from_seed(act_seed);
		next_cycle();
		rd_strobe = 1'b1;
		rd_index  = wb_pkg::addr_t'(index);
		act_word  = act;
		exp_step.push_back(step + 4);
		for (int r = 0; r < wb_pkg::ROWS; r++)
			exp_sum.push_back(expected_row(r, index, act));
	endtask

	task automatic drain_reads();
		int waited;
		waited = 0;
		do begin
			next_cycle();
			rd_strobe = 1'b0;
			waited++;
			if (waited > TIMEOUT)
				stop_with_failure("expected read results never arrived");
		end while (exp_step.size() > 0);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		wb_pkg::acc_t old_sum;
		int           reload_addr;
		reset      = 1'b1;
		lane_valid = 1'b0;
		lane_data  = '0;
		load_bank  = '0;
		load_addr  = '0;
		rd_strobe  = 1'b0;
		rd_index   = '0;
		act_word   = '0;
		step       = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// nothing may come out while idle after reset
		repeat (4) begin
			next_cycle();
			check_bit("load_busy", load_busy, 1'b0);
		end

		for (int b = 0; b < wb_pkg::ROWS; b++)
			for (int a = 0; a < wb_pkg::DEPTH; a++)
				load_word(b, a, random_word());

		for (int i = 0; i < N_READS; i++) begin
			if (tbl_reload[i] != 0) begin
				drain_reads();
				reload_addr = (tbl_index[i] + 1) % wb_pkg::DEPTH;
				old_sum = expected_row(1, tbl_index[i], act_from_seed(tbl_seed[i]));
				load_word(1, reload_addr, random_word());
				if (expected_row(1, tbl_index[i], act_from_seed(tbl_seed[i])) == old_sum)
					stop_with_failure("reloaded word gives the same sum_1 as before");
			end
			issue_read(tbl_index[i], tbl_seed[i]);
		end
		drain_reads();

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: conv_weight_engine.f
rtl/wb_pkg.sv
rtl/weight_read_if.sv
rtl/weight_bank.sv
rtl/weight_loader.sv
rtl/weight_buffer.sv
rtl/kernel_row_dot.sv
rtl/conv_weight_engine.sv
sim/conv_weight_engine_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the conv_weight_engine testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
	--top-module conv_weight_engine_tb \
	--Mdir obj_dir -o conv_weight_engine_sim \
	-f conv_weight_engine.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/conv_weight_engine_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF '*** TEST PASSED ***' "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
